// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run from the project root, judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rv_lsu_tb -f rv_lsu.f -o rv_lsu_sim \
    && ./obj_dir/rv_lsu_sim | tee sim.log \
    && grep -qx "TEST PASSED" sim.log \
    && echo "simulation ok" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== rv_lsu.f ====
+incdir+source
source/rv_lsu_pkg.sv
source/mem_req_if.sv
source/data_ram.sv
source/mmio_regs.sv
source/lsu_steer.sv
source/rv_lsu_top.sv
verification/rv_lsu_chk.sv
verification/rv_lsu_tb.sv

// ==== source/data_ram.sv ====
`timescale 1ns/1ns
`include "rv_lsu_params.svh"

module data_ram #(
    parameter int MEM_SIZE_P = `MEM_SIZE   // bytes, a power of two up to the local range.
) (
    input logic       clk_i,
    mem_req_if.memory bus_i
);
    import rv_lsu_pkg::*;

    localparam int IDX_W = $clog2(MEM_SIZE_P);

    logic [7:0]             mem [MEM_SIZE_P];   // one entry per byte lane.
    logic [IDX_W-3:0]       w_word;             // word index of the store.
    logic [IDX_W-3:0]       r_word;             // word index of the load.
    logic [3:0]             w_be;               // byte enables within the word.
    logic [`DATA_WIDTH-1:0] w_lanes;            // store data moved to its lanes.

    assign w_word = bus_i.waddr[IDX_W-1:2];
    assign r_word = bus_i.raddr[IDX_W-1:2];

    // one, two or four lanes starting at the low address bits.
    always_comb begin
        case (bus_i.wsize)
            SIZE_BYTE: w_be = 4'b0001 << bus_i.waddr[1:0];
            SIZE_HALF: w_be = 4'b0011 << bus_i.waddr[1:0];
            default:   w_be = 4'b1111;
        endcase
    end

    // little endian, so byte k of the data lands in lane offset+k.
    assign w_lanes = bus_i.wdata << {bus_i.waddr[1:0], 3'b000};

    always_ff @(posedge clk_i) begin
        if (bus_i.we) begin
            for (int i = 0; i < 4; i++) begin
                if (w_be[i]) begin
                    mem[{w_word, 2'(i)}] <= w_lanes[8*i +: 8];
                end
            end
        end
    end

    // read port returns the whole word, the steering logic picks the lanes
    always_comb begin
        if (bus_i.re) begin
            bus_i.rdata = {mem[{r_word, 2'd3}],
                           mem[{r_word, 2'd2}],
                           mem[{r_word, 2'd1}],
                           mem[{r_word, 2'd0}]};
        end else begin
            bus_i.rdata = '0;
        end
    end

endmodule

// ==== source/lsu_steer.sv ====
`timescale 1ns/1ns
`include "rv_lsu_params.svh"

module lsu_steer (
    input  logic                       re_i,
    input  logic                       we_i,
    input  logic [`SYS_ADDR_SPACE-1:0] r_addr_i,
    input  logic [`SYS_ADDR_SPACE-1:0] w_addr_i,
    input  logic [`DATA_WIDTH-1:0]     w_data_i,
    input  rv_lsu_pkg::funct3_u        r_mode_i,
    input  rv_lsu_pkg::funct3_u        w_mode_i,
    mem_req_if.requester               ram_o,
    mem_req_if.requester               mmio_o,
    output logic [`DATA_WIDTH-1:0]     data_o,
    output logic                       load_err_o,
    output logic                       store_err_o
);
    import rv_lsu_pkg::*;

    logic                       r_in_ram, r_in_mmio, w_in_ram, w_in_mmio;
    logic                       r_mode_ok, w_mode_ok;
    logic                       load_err, store_err;
    logic [`SYS_ADDR_SPACE-1:0] r_ram_ofs, r_mmio_ofs, w_ram_ofs, w_mmio_ofs;
    logic [`DATA_WIDTH-1:0]     rd_word, rd_shift;

    function automatic logic hits_ram(input logic [`SYS_ADDR_SPACE-1:0] addr);
        logic [`SYS_ADDR_SPACE-1:0] rel;
        rel = addr - `MEM_BASE;
        return rel < `SYS_ADDR_SPACE'(`MEM_SIZE);
    endfunction

    function automatic logic hits_mmio(input logic [`SYS_ADDR_SPACE-1:0] addr);
        return (addr == `MMIO_BASE + `MMIO_GPIO_OFS) ||
               (addr == `MMIO_BASE + `MMIO_SCRATCH_OFS) ||
               (addr == `MMIO_BASE + `MMIO_ID_OFS);
    endfunction

    // half needs even, word needs 4-aligned.
    function automatic logic misaligned(input access_size_e size, input logic [1:0] lo);
        return (size == SIZE_HALF && lo[0]) || (size == SIZE_WORD && lo != 2'b00);
    endfunction

    assign r_in_ram  = hits_ram(r_addr_i);
    assign r_in_mmio = hits_mmio(r_addr_i);
    assign w_in_ram  = hits_ram(w_addr_i);
    assign w_in_mmio = hits_mmio(w_addr_i);

    assign r_mode_ok = r_mode_i.raw inside {LB, LH, LW, LBU, LHU};
    assign w_mode_ok = w_mode_i.raw inside {SB, SH, SW};

    assign load_err = re_i && (!(r_in_ram || r_in_mmio) || !r_mode_ok ||
                               misaligned(r_mode_i.f.size, r_addr_i[1:0]) ||
                               (r_in_mmio && r_mode_i.f.size != SIZE_WORD));

    assign store_err = we_i && (!(w_in_ram || w_in_mmio) || !w_mode_ok ||
                                misaligned(w_mode_i.f.size, w_addr_i[1:0]) ||
                                (w_in_mmio && w_mode_i.f.size != SIZE_WORD) ||
                                (w_addr_i == `MMIO_BASE + `MMIO_ID_OFS));

    assign load_err_o  = load_err;
    assign store_err_o = store_err;

    // local offsets inside each target.
    assign r_ram_ofs  = r_addr_i - `MEM_BASE;
    assign w_ram_ofs  = w_addr_i - `MEM_BASE;
    assign r_mmio_ofs = r_addr_i - `MMIO_BASE;
    assign w_mmio_ofs = w_addr_i - `MMIO_BASE;

    // a faulting access reaches no target.
    assign ram_o.re     = re_i && !load_err && r_in_ram;
    assign ram_o.we     = we_i && !store_err && w_in_ram;
    assign ram_o.raddr  = r_ram_ofs[`MEM_ADDR_SPACE-1:0];
    assign ram_o.waddr  = w_ram_ofs[`MEM_ADDR_SPACE-1:0];
    assign ram_o.wdata  = w_data_i;
    assign ram_o.wsize  = w_mode_i.f.size;

    assign mmio_o.re    = re_i && !load_err && r_in_mmio;
    assign mmio_o.we    = we_i && !store_err && w_in_mmio;
    assign mmio_o.raddr = r_mmio_ofs[`MEM_ADDR_SPACE-1:0];
    assign mmio_o.waddr = w_mmio_ofs[`MEM_ADDR_SPACE-1:0];
    assign mmio_o.wdata = w_data_i;
    assign mmio_o.wsize = w_mode_i.f.size;

    // pick the target word, move the addressed lane down, then extend.
    always_comb begin
        rd_word  = r_in_ram ? ram_o.rdata : mmio_o.rdata;
        rd_shift = rd_word >> {r_addr_i[1:0], 3'b000};
        case (r_mode_i.f.size)
            SIZE_BYTE: data_o = r_mode_i.f.is_unsigned ? {24'b0, rd_shift[7:0]}
                                                       : {{24{rd_shift[7]}}, rd_shift[7:0]};
            SIZE_HALF: data_o = r_mode_i.f.is_unsigned ? {16'b0, rd_shift[15:0]}
                                                       : {{16{rd_shift[15]}}, rd_shift[15:0]};
            default:   data_o = rd_word;
        endcase
        if (!re_i || load_err) begin
            data_o = '0;                      // idle or faulting load.
        end
    end

endmodule

// ==== source/mem_req_if.sv ====
`timescale 1ns/1ns
`include "rv_lsu_params.svh"

interface mem_req_if;
    import rv_lsu_pkg::*;

    logic                       re;      // read strobe.
    logic                       we;      // write strobe.
    logic [`MEM_ADDR_SPACE-1:0] raddr;   // local read byte address.
    logic [`MEM_ADDR_SPACE-1:0] waddr;   // local write byte address.
    logic [`DATA_WIDTH-1:0]     wdata;   // store data in the low lanes.
    access_size_e               wsize;   // store width.
    logic [`DATA_WIDTH-1:0]     rdata;   // aligned read word.

    // the LSU side issues requests.
    modport requester (
        output re, we, raddr, waddr, wdata, wsize,
        input  rdata
    );

    // a target answers them.
    modport memory (
        input  re, we, raddr, waddr, wdata, wsize,
        output rdata
    );

endinterface

// ==== source/mmio_regs.sv ====
`timescale 1ns/1ns
`include "rv_lsu_params.svh"

module mmio_regs (
    input  logic                   clk_i,
    input  logic                   reset_i,
    mem_req_if.memory              bus_i,
    output logic [`DATA_WIDTH-1:0] gpio_o
);

    // register select codes taken from address bits 3:2.
    localparam logic [1:0] GPIO_SEL    = 2'(`MMIO_GPIO_OFS >> 2);
    localparam logic [1:0] SCRATCH_SEL = 2'(`MMIO_SCRATCH_OFS >> 2);
    localparam logic [1:0] ID_SEL      = 2'(`MMIO_ID_OFS >> 2);

    logic [`DATA_WIDTH-1:0] gpio_q;      // drives the output pins.
    logic [`DATA_WIDTH-1:0] scratch_q;   // free software storage.

    // whole-word writes only. the ID slot ignores stores
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            gpio_q    <= '0;
            scratch_q <= '0;
        end else if (bus_i.we) begin
            case (bus_i.waddr[3:2])
                GPIO_SEL:    gpio_q    <= bus_i.wdata;
                SCRATCH_SEL: scratch_q <= bus_i.wdata;
                default:     ;                           // read-only slot.
            endcase
        end
    end

    always_comb begin
        bus_i.rdata = '0;
        if (bus_i.re) begin
            case (bus_i.raddr[3:2])
                GPIO_SEL:    bus_i.rdata = gpio_q;
                SCRATCH_SEL: bus_i.rdata = scratch_q;
                ID_SEL:      bus_i.rdata = `LSU_ID;
                default:     bus_i.rdata = '0;   // hole in the map.
            endcase
        end
    end

    assign gpio_o = gpio_q;

endmodule

// ==== source/rv_lsu_params.svh ====
`ifndef RV_LSU_PARAMS_SVH
`define RV_LSU_PARAMS_SVH

// bus and data widths.
`define SYS_ADDR_SPACE 32
`define DATA_WIDTH 32

// data RAM geometry.
`define MEM_ADDR_SPACE 10
`define MEM_SIZE 1024

// memory map.
`define MEM_BASE 32'h0000_0000
`define MMIO_BASE 32'h1000_0000

// register offsets inside the MMIO block.
`define MMIO_GPIO_OFS 32'h0000_0000
`define MMIO_SCRATCH_OFS 32'h0000_0004
`define MMIO_ID_OFS 32'h0000_0008

// value returned by the read-only ID register.
`define LSU_ID 32'h1515_0001

`endif

// ==== source/rv_lsu_pkg.sv ====
package rv_lsu_pkg;

    // low two funct3 bits give the access width.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    typedef struct packed {
        logic         is_unsigned;   // funct3[2] set on LBU and LHU.
        access_size_e size;          // funct3[1:0].
    } funct3_fields_t;

    // the same three bits read as an opcode or as flag plus size.
    typedef union packed {
        logic [2:0]     raw;
        funct3_fields_t f;
    } funct3_u;

    // load funct3 codes.
    localparam logic [2:0] LB  = 3'b000;
    localparam logic [2:0] LH  = 3'b001;
    localparam logic [2:0] LW  = 3'b010;
    localparam logic [2:0] LBU = 3'b100;
    localparam logic [2:0] LHU = 3'b101;

    // store funct3 codes.
    localparam logic [2:0] SB  = 3'b000;
    localparam logic [2:0] SH  = 3'b001;
    localparam logic [2:0] SW  = 3'b010;

endpackage

// ==== source/rv_lsu_top.sv ====
`timescale 1ns/1ns
`include "rv_lsu_params.svh"

module rv_lsu_top (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       re_i,        // read enable.
    input  logic                       we_i,        // write enable.
    input  logic [`SYS_ADDR_SPACE-1:0] r_addr_i,
    input  logic [`SYS_ADDR_SPACE-1:0] w_addr_i,
    input  logic [`DATA_WIDTH-1:0]     w_data_i,
    input  rv_lsu_pkg::funct3_u        r_mode_i,    // load funct3.
    input  rv_lsu_pkg::funct3_u        w_mode_i,    // store funct3.
    output logic [`DATA_WIDTH-1:0]     data_o,
    output logic                       load_err_o,
    output logic                       store_err_o,
    output logic [`DATA_WIDTH-1:0]     gpio_o
);

    mem_req_if ram_bus ();    // steering logic to data RAM.
    mem_req_if mmio_bus ();   // steering logic to MMIO block.

    lsu_steer u_steer (
        .re_i        (re_i),
        .we_i        (we_i),
        .r_addr_i    (r_addr_i),
        .w_addr_i    (w_addr_i),
        .w_data_i    (w_data_i),
        .r_mode_i    (r_mode_i),
        .w_mode_i    (w_mode_i),
        .ram_o       (ram_bus),
        .mmio_o      (mmio_bus),
        .data_o      (data_o),
        .load_err_o  (load_err_o),
        .store_err_o (store_err_o)
    );

    data_ram #(
        .MEM_SIZE_P (`MEM_SIZE)
    ) u_ram (
        .clk_i (clk_i),
        .bus_i (ram_bus)
    );

    mmio_regs u_mmio (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .bus_i   (mmio_bus),
        .gpio_o  (gpio_o)
    );

endmodule

// ==== verification/rv_lsu_chk.sv ====
`timescale 1ns/1ns
`include "rv_lsu_params.svh"

module rv_lsu_chk (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic [`DATA_WIDTH-1:0] data_i,
    input logic                   load_err_i,
    input logic                   store_err_i,
    input logic [`DATA_WIDTH-1:0] gpio_i,
    input logic                   ram_re_i,
    input logic                   mmio_re_i
);

    a_load_err_data: assert property (@(posedge clk_i) load_err_i |-> (data_i == '0))
        else $error("data_o is nonzero during a load error.");

    // a rejected store must not touch the GPIO register.
    a_store_err_gpio: assert property (@(posedge clk_i) disable iff (reset_i)
                                       store_err_i |=> $stable(gpio_i))
        else $error("gpio_o changed after a rejected store.");

    a_reset_gpio: assert property (@(posedge clk_i) reset_i |=> (gpio_i == '0))
        else $error("gpio_o not cleared by reset.");

    a_one_target: assert property (@(posedge clk_i) !(ram_re_i && mmio_re_i))
        else $error("both targets selected for one load.");

endmodule

bind rv_lsu_top rv_lsu_chk u_chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .data_i      (data_o),
    .load_err_i  (load_err_o),
    .store_err_i (store_err_o),
    .gpio_i      (gpio_o),
    .ram_re_i    (ram_bus.re),
    .mmio_re_i   (mmio_bus.re)
);

// ==== verification/rv_lsu_tb.sv ====
`timescale 1ns/1ns
`include "rv_lsu_params.svh"

module rv_lsu_tb;
    import rv_lsu_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DLY   = 1;                          // inputs change after the edge.
    localparam int SAMPLE_DLY  = CLK_PERIOD - 3;             // outputs checked near the next edge.
    localparam int FIELDS      = 11;                         // columns per line of the data file.
    localparam int MAX_WORDS   = 1024;
    localparam int MAX_LINES   = MAX_WORDS / FIELDS;
    localparam int RAND_CNT    = 16;                         // random word stores before the file.
    localparam int RAND_CYCLES = 2 * RAND_CNT;               // each store is read back.

    logic                       clk_i;
    logic                       reset_i;
    logic                       re_i;
    logic                       we_i;
    logic [`SYS_ADDR_SPACE-1:0] r_addr_i;
    logic [`SYS_ADDR_SPACE-1:0] w_addr_i;
    logic [`DATA_WIDTH-1:0]     w_data_i;
    funct3_u                    r_mode_i;
    funct3_u                    w_mode_i;
    logic [`DATA_WIDTH-1:0]     data_o;
    logic                       load_err_o;
    logic                       store_err_o;
    logic [`DATA_WIDTH-1:0]     gpio_o;

    logic [31:0] vec [MAX_WORDS];    // flat copy of the data file.
    int          num_lines;
    int          step_no;
    int          seed;
    bit          lines_ready;        // watchdog waits for the line count.

    rv_lsu_top u_dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .re_i        (re_i),
        .we_i        (we_i),
        .r_addr_i    (r_addr_i),
        .w_addr_i    (w_addr_i),
        .w_data_i    (w_data_i),
        .r_mode_i    (r_mode_i),
        .w_mode_i    (w_mode_i),
        .data_o      (data_o),
        .load_err_o  (load_err_o),
        .store_err_o (store_err_o),
        .gpio_o      (gpio_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at step %0d", name, got, exp, step_no);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] vec_word(input int line, input int col);
        return vec[10'(line * FIELDS + col)];
    endfunction

    // one access per cycle, called just after a rising edge.
    task automatic run_step(input logic [31:0] re,
                            input logic [31:0] we,
                            input logic [31:0] raddr,
                            input logic [31:0] waddr,
                            input logic [31:0] wdata,
                            input logic [31:0] rmode,
                            input logic [31:0] wmode,
                            input logic [31:0] exp_data,
                            input logic [31:0] exp_lerr,
                            input logic [31:0] exp_serr,
                            input logic [31:0] exp_gpio);
        re_i         = re[0];
        we_i         = we[0];
        r_addr_i     = raddr;
        w_addr_i     = waddr;
        w_data_i     = wdata;
        r_mode_i.raw = rmode[2:0];
        w_mode_i.raw = wmode[2:0];
        #(SAMPLE_DLY);
        check_val("data_o", data_o, exp_data);
        check_val("load_err_o", 32'(load_err_o), exp_lerr);
        check_val("store_err_o", 32'(store_err_o), exp_serr);
        @(posedge clk_i);
        #(DRIVE_DLY);
        check_val("gpio_o", gpio_o, exp_gpio);    // store lands on the edge.
        step_no++;
    endtask

    task automatic load_vectors();
        for (int i = 0; i < MAX_WORDS; i++) begin
            vec[10'(i)] = '1;                     // all ones marks the end of the file.
        end
        $readmemh("verification/rv_lsu_testdata.txt", vec);
        num_lines = 0;
        while (num_lines < MAX_LINES && vec_word(num_lines, 0) !== '1) begin
            num_lines++;
        end
        lines_ready = 1'b1;
    endtask

    // word stores at random RAM addresses, each read back in the next cycle.
    task automatic fill_ram_random();
        logic [31:0] rnd_addr;
        logic [31:0] rnd_data;
        for (int i = 0; i < RAND_CNT; i++) begin
            rnd_addr = `MEM_BASE + ($random(seed) & (`MEM_SIZE - 4));
            rnd_data = $random(seed);
            run_step(0, 1, 0, rnd_addr, rnd_data, 32'(LW), 32'(SW), 0, 0, 0, 0);
            run_step(1, 0, rnd_addr, 0, 0, 32'(LW), 32'(SW), rnd_data, 0, 0, 0);
        end
    endtask

    task automatic run_file_lines();
        for (int ln = 0; ln < num_lines; ln++) begin
            run_step(vec_word(ln, 0), vec_word(ln, 1), vec_word(ln, 2), vec_word(ln, 3),
                     vec_word(ln, 4), vec_word(ln, 5), vec_word(ln, 6), vec_word(ln, 7),
                     vec_word(ln, 8), vec_word(ln, 9), vec_word(ln, 10));
        end
    endtask

    initial begin : main
        clk_i    = 1'b0;
        reset_i  = 1'b1;
        re_i     = 1'b0;
        we_i     = 1'b0;
        r_addr_i = '0;
        w_addr_i = '0;
        w_data_i = '0;
        r_mode_i = '0;
        w_mode_i = '0;
        step_no  = 0;
        seed     = 32'hf03f_f002;
        load_vectors();
        repeat (2) @(posedge clk_i);
        #(DRIVE_DLY);
        reset_i = 1'b0;
        if (num_lines == 0) begin
            $display("no stimulus lines could be read from the data file");
            $display("TEST FAILED");
            $fatal(1, "empty stimulus");
        end else begin
            fill_ram_random();
            run_file_lines();
            $display("TEST PASSED");
            $finish;
        end
    end

    initial begin : watchdog
        int limit_ns;
        wait (lines_ready);
        limit_ns = (num_lines + RAND_CYCLES + 10) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout, the run did not finish within %0d ns", limit_ns);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verification/rv_lsu_testdata.txt ====
// re we r_addr w_addr w_data r_mode w_mode exp_data exp_load_err exp_store_err exp_gpio
// all hex, modes are funct3 codes, exp_gpio is the value after the clock edge
1 0 10000004 00000000 00000000 2 0 00000000 0 0 00000000
1 0 10000000 00000000 00000000 2 0 00000000 0 0 00000000
1 0 10000008 00000000 00000000 2 0 15150001 0 0 00000000
0 1 00000000 00000100 12F08A7C 0 2 00000000 0 0 00000000
1 0 00000100 00000000 00000000 2 0 12F08A7C 0 0 00000000
1 0 00000100 00000000 00000000 0 0 0000007C 0 0 00000000
1 0 00000101 00000000 00000000 0 0 FFFFFF8A 0 0 00000000
1 0 00000101 00000000 00000000 4 0 0000008A 0 0 00000000
1 0 00000102 00000000 00000000 0 0 FFFFFFF0 0 0 00000000
1 0 00000102 00000000 00000000 4 0 000000F0 0 0 00000000
1 0 00000103 00000000 00000000 0 0 00000012 0 0 00000000
1 0 00000100 00000000 00000000 1 0 FFFF8A7C 0 0 00000000
1 0 00000100 00000000 00000000 5 0 00008A7C 0 0 00000000
1 0 00000102 00000000 00000000 1 0 000012F0 0 0 00000000
0 1 00000000 00000104 11223344 0 2 00000000 0 0 00000000
1 1 00000104 00000106 ABCDC3B5 2 1 11223344 0 0 00000000
1 0 00000104 00000000 00000000 2 0 C3B53344 0 0 00000000
1 0 00000106 00000000 00000000 5 0 0000C3B5 0 0 00000000
1 0 00000106 00000000 00000000 1 0 FFFFC3B5 0 0 00000000
0 1 00000000 00000105 000000E7 0 0 00000000 0 0 00000000
1 0 00000104 00000000 00000000 2 0 C3B5E744 0 0 00000000
1 0 00000105 00000000 00000000 0 0 FFFFFFE7 0 0 00000000
1 1 00000100 00000102 0000005A 2 0 12F08A7C 0 0 00000000
1 0 00000100 00000000 00000000 2 0 125A8A7C 0 0 00000000
1 1 10000000 10000000 A5A50F0F 2 2 00000000 0 0 A5A50F0F
1 0 10000000 00000000 00000000 2 0 A5A50F0F 0 0 A5A50F0F
0 1 00000000 10000004 600DCAFE 0 2 00000000 0 0 A5A50F0F
1 0 10000004 00000000 00000000 2 0 600DCAFE 0 0 A5A50F0F
1 0 00000101 00000000 00000000 1 0 00000000 1 0 A5A50F0F
1 0 00000102 00000000 00000000 2 0 00000000 1 0 A5A50F0F
1 1 00000104 00000106 FFFFFFFF 2 2 C3B5E744 0 1 A5A50F0F
1 0 00000104 00000000 00000000 2 0 C3B5E744 0 0 A5A50F0F
1 1 00000400 20000000 DEADBEEF 2 2 00000000 1 1 A5A50F0F
1 1 1000000C 00000400 DEADBEEF 2 2 00000000 1 1 A5A50F0F
1 1 00000100 00000100 FFFFFFFF 3 3 00000000 1 1 A5A50F0F
1 0 00000100 00000000 00000000 2 0 125A8A7C 0 0 A5A50F0F
1 1 10000000 10000000 000000FF 0 0 00000000 1 1 A5A50F0F
1 1 10000008 10000008 00000000 2 2 15150001 0 1 A5A50F0F
0 1 00000000 10000000 00000000 0 7 00000000 0 1 A5A50F0F
0 0 00000100 00000000 00000000 2 0 00000000 0 0 A5A50F0F
0 0 00000403 00000000 00000000 7 0 00000000 0 0 A5A50F0F
0 0 10000001 00000000 00000000 1 0 00000000 0 0 A5A50F0F
1 0 10000008 00000000 00000000 2 0 15150001 0 0 A5A50F0F
1 0 10000000 00000000 00000000 2 0 A5A50F0F 0 0 A5A50F0F
